/* Makefile */
.PHONY: all lint sim clean

all: sim

lint:
	verilator --lint-only --timing --timescale 1ns/1ps --top-module exec_core_tb -f filelist.f

sim:
	verilator --binary --timescale 1ns/1ps --top-module exec_core_tb -Mdir obj_dir -f filelist.f
	@out="$$(./obj_dir/Vexec_core_tb)"; \
	echo "$$out"; \
	echo "$$out" | grep -qx "test passed"

clean:
	rm -rf obj_dir

/* design/alu_exec.sv */
`timescale 1ns/1ps
`default_nettype none

module alu_exec (
    input  rv_exec_pkg::id_ex_t  id_ex_i,
    output rv_exec_pkg::ex_res_t ex_res_o
);

    logic [rv_exec_pkg::xlen-1:0] res;
    logic [4:0]                   shamt;
    logic                         is_mem;

    assign shamt = id_ex_i.reg2[4:0];

    always_comb begin
        case (id_ex_i.alu_op)
            rv_exec_pkg::op_lui:   res = id_ex_i.reg2;
            rv_exec_pkg::op_auipc: res = id_ex_i.reg1 + id_ex_i.reg2;
            rv_exec_pkg::op_add:   res = id_ex_i.reg1 + id_ex_i.reg2;
            rv_exec_pkg::op_sub:   res = id_ex_i.reg1 - id_ex_i.reg2;
            rv_exec_pkg::op_sll:   res = id_ex_i.reg1 << shamt;
            rv_exec_pkg::op_slt: begin
                res = ($signed(id_ex_i.reg1) < $signed(id_ex_i.reg2)) ? 32'd1 : 32'd0;
            end
            rv_exec_pkg::op_sltu:  res = (id_ex_i.reg1 < id_ex_i.reg2) ? 32'd1 : 32'd0;
            rv_exec_pkg::op_xor:   res = id_ex_i.reg1 ^ id_ex_i.reg2;
            rv_exec_pkg::op_srl:   res = id_ex_i.reg1 >> shamt;
            rv_exec_pkg::op_sra:   res = $unsigned($signed(id_ex_i.reg1) >>> shamt);
            rv_exec_pkg::op_or:    res = id_ex_i.reg1 | id_ex_i.reg2;
            rv_exec_pkg::op_and:   res = id_ex_i.reg1 & id_ex_i.reg2;

            // Byte and half selection happens in the memory stage
            rv_exec_pkg::op_lb, rv_exec_pkg::op_lh, rv_exec_pkg::op_lw,
            rv_exec_pkg::op_lbu, rv_exec_pkg::op_lhu,
            rv_exec_pkg::op_sb, rv_exec_pkg::op_sh, rv_exec_pkg::op_sw: begin
                res = id_ex_i.reg1 + id_ex_i.reg2;
            end

            rv_exec_pkg::op_jump:  res = id_ex_i.addr_for_rd;
            default:               res = '0;
        endcase
    end

    always_comb begin
        case (id_ex_i.alu_op)
            rv_exec_pkg::op_lb, rv_exec_pkg::op_lh, rv_exec_pkg::op_lw,
            rv_exec_pkg::op_lbu, rv_exec_pkg::op_lhu,
            rv_exec_pkg::op_sb, rv_exec_pkg::op_sh, rv_exec_pkg::op_sw: is_mem = 1'b1;
            default: is_mem = 1'b0;
        endcase
    end

    always_comb begin
        ex_res_o.rd_addr   = id_ex_i.rd;
        ex_res_o.rd_enable = id_ex_i.rd_enable;
        ex_res_o.alu_op    = id_ex_i.alu_op;
        ex_res_o.mem_wdata = id_ex_i.store_data;
        if (is_mem) begin
            ex_res_o.mem_addr = res;
            ex_res_o.rd_data  = '0;
        end else begin
            ex_res_o.mem_addr = '0;
            ex_res_o.rd_data  = res;
        end
    end

endmodule

`default_nettype wire

/* design/ex_mem_reg.sv */
`timescale 1ns/1ps
`default_nettype none

module ex_mem_reg (
    input  logic                  clk_i,
    input  logic                  reset_i,
    input  rv_exec_pkg::ex_res_t  ex_res_i,
    output rv_exec_pkg::wb_t      wb_o,
    output rv_exec_pkg::mem_req_t mem_req_o
);

    rv_exec_pkg::wb_t      wb_d;
    rv_exec_pkg::mem_req_t mem_req_d;

    always_comb begin
        wb_d.enable = ex_res_i.rd_enable;
        wb_d.addr   = ex_res_i.rd_addr;
        wb_d.data   = ex_res_i.rd_data;

        mem_req_d.op    = ex_res_i.alu_op;
        mem_req_d.addr  = ex_res_i.mem_addr;
        mem_req_d.wdata = ex_res_i.mem_wdata;
        case (ex_res_i.alu_op)
            rv_exec_pkg::op_lb, rv_exec_pkg::op_lh, rv_exec_pkg::op_lw,
            rv_exec_pkg::op_lbu, rv_exec_pkg::op_lhu,
            rv_exec_pkg::op_sb, rv_exec_pkg::op_sh, rv_exec_pkg::op_sw: begin
                mem_req_d.valid = 1'b1;
            end
            default: mem_req_d.valid = 1'b0;
        endcase
    end

    always_ff @(posedge clk_i) begin
        if (reset_i) begin
            wb_o      <= '0;
            mem_req_o <= '0;
        end else begin
            wb_o      <= wb_d;
            mem_req_o <= mem_req_d;
        end
    end

endmodule

`default_nettype wire

/* design/exec_core_top.sv */
`timescale 1ns/1ps
`default_nettype none

module exec_core_top (
    input  logic                         clk_i,
    input  logic                         reset_i,
    input  logic                         inst_valid_i,
    input  logic [31:0]                  inst_i,
    input  logic [rv_exec_pkg::xlen-1:0] pc_i,
    output rv_exec_pkg::wb_t             wb_o,
    output rv_exec_pkg::mem_req_t        mem_req_o
);

    logic [rv_exec_pkg::reg_addr_w-1:0] rs1_addr;
    logic [rv_exec_pkg::reg_addr_w-1:0] rs2_addr;
    logic [rv_exec_pkg::xlen-1:0]       rs1_data;
    logic [rv_exec_pkg::xlen-1:0]       rs2_data;
    rv_exec_pkg::id_ex_t                id_ex;
    rv_exec_pkg::ex_res_t               ex_res;

    inst_decode u_decode (
        .clk_i        (clk_i),
        .reset_i      (reset_i),
        .inst_valid_i (inst_valid_i),
        .inst_i       (inst_i),
        .pc_i         (pc_i),
        .rs1_addr_o   (rs1_addr),
        .rs2_addr_o   (rs2_addr),
        .rs1_data_i   (rs1_data),
        .rs2_data_i   (rs2_data),
        .ex_fwd_i     (ex_res),
        .wb_fwd_i     (wb_o),
        .id_ex_o      (id_ex)
    );

    reg_file u_reg_file (
        .clk_i      (clk_i),
        .reset_i    (reset_i),
        .rs1_addr_i (rs1_addr),
        .rs2_addr_i (rs2_addr),
        .rs1_data_o (rs1_data),
        .rs2_data_o (rs2_data),
        .wb_i       (wb_o)
    );

    alu_exec u_alu (
        .id_ex_i  (id_ex),
        .ex_res_o (ex_res)
    );

    ex_mem_reg u_ex_mem (
        .clk_i     (clk_i),
        .reset_i   (reset_i),
        .ex_res_i  (ex_res),
        .wb_o      (wb_o),
        .mem_req_o (mem_req_o)
    );

endmodule

`default_nettype wire

/* design/inst_decode.sv */
`timescale 1ns/1ps
`default_nettype none

module inst_decode (
    input  logic                                clk_i,
    input  logic                                reset_i,
    input  logic                                inst_valid_i,
    input  rv_exec_pkg::rv_inst_u               inst_i,
    input  logic [rv_exec_pkg::xlen-1:0]        pc_i,
    output logic [rv_exec_pkg::reg_addr_w-1:0]  rs1_addr_o,
    output logic [rv_exec_pkg::reg_addr_w-1:0]  rs2_addr_o,
    input  logic [rv_exec_pkg::xlen-1:0]        rs1_data_i,
    input  logic [rv_exec_pkg::xlen-1:0]        rs2_data_i,
    input  rv_exec_pkg::ex_res_t                ex_fwd_i,
    input  rv_exec_pkg::wb_t                    wb_fwd_i,
    output rv_exec_pkg::id_ex_t                 id_ex_o
);

    logic [rv_exec_pkg::xlen-1:0] imm_i;
    logic [rv_exec_pkg::xlen-1:0] imm_s;
    logic [rv_exec_pkg::xlen-1:0] imm_b;
    logic [rv_exec_pkg::xlen-1:0] imm_u;
    logic [rv_exec_pkg::xlen-1:0] imm_j;
    logic [rv_exec_pkg::xlen-1:0] rs1_val;
    logic [rv_exec_pkg::xlen-1:0] rs2_val;
    rv_exec_pkg::id_ex_t          id_ex_d;

    // The execute stage holds the newest value and write-back the next newest
    function automatic logic [rv_exec_pkg::xlen-1:0] fwd_sel(
        input logic [rv_exec_pkg::reg_addr_w-1:0] addr,
        input logic [rv_exec_pkg::xlen-1:0]       rf_data
    );
        logic [rv_exec_pkg::xlen-1:0] val;
        val = rf_data;
        if (ex_fwd_i.rd_enable && ex_fwd_i.rd_addr == addr) begin
            val = ex_fwd_i.rd_data;
        end else if (wb_fwd_i.enable && wb_fwd_i.addr == addr) begin
            val = wb_fwd_i.data;
        end
        return val;
    endfunction

    assign rs1_addr_o = inst_i.r_fmt.rs1;
    assign rs2_addr_o = inst_i.r_fmt.rs2;

    assign imm_i = {{20{inst_i.i_fmt.imm[11]}}, inst_i.i_fmt.imm};
    assign imm_s = {{20{inst_i.s_fmt.imm_hi[6]}}, inst_i.s_fmt.imm_hi, inst_i.s_fmt.imm_lo};
    assign imm_b = {{20{inst_i.r_fmt.funct7[6]}}, inst_i.r_fmt.rd[0],
                    inst_i.r_fmt.funct7[5:0], inst_i.r_fmt.rd[4:1], 1'b0};
    assign imm_u = {inst_i.u_fmt.imm, 12'b0};
    assign imm_j = {{12{inst_i.u_fmt.imm[19]}}, inst_i.u_fmt.imm[7:0],
                    inst_i.u_fmt.imm[8], inst_i.u_fmt.imm[18:9], 1'b0};

    assign rs1_val = fwd_sel(inst_i.r_fmt.rs1, rs1_data_i);
    assign rs2_val = fwd_sel(inst_i.r_fmt.rs2, rs2_data_i);

    always_comb begin
        id_ex_d             = '0;
        id_ex_d.reg1        = rs1_val;
        id_ex_d.reg2        = rs2_val;
        id_ex_d.store_data  = rs2_val;
        id_ex_d.rd          = inst_i.r_fmt.rd;
        id_ex_d.addr_for_rd = pc_i + 32'd4;
        id_ex_d.alu_op      = rv_exec_pkg::op_none;

        case (inst_i.r_fmt.opcode)
            rv_exec_pkg::opc_lui: begin
                id_ex_d.reg2   = imm_u;
                id_ex_d.alu_op = rv_exec_pkg::op_lui;
            end
            rv_exec_pkg::opc_auipc: begin
                id_ex_d.reg1   = pc_i;
                id_ex_d.reg2   = imm_u;
                id_ex_d.alu_op = rv_exec_pkg::op_auipc;
            end
            rv_exec_pkg::opc_jal: begin
                id_ex_d.reg1   = pc_i;
                id_ex_d.reg2   = imm_j;
                id_ex_d.alu_op = rv_exec_pkg::op_jump;
            end
            rv_exec_pkg::opc_jalr: begin
                id_ex_d.reg2   = imm_i;
                id_ex_d.alu_op = rv_exec_pkg::op_jump;
            end
            rv_exec_pkg::opc_branch: begin
                // Only the target operands are formed since the fetch side resolves the branch
                id_ex_d.reg1 = pc_i;
                id_ex_d.reg2 = imm_b;
            end
            rv_exec_pkg::opc_load: begin
                id_ex_d.reg2 = imm_i;
                case (inst_i.i_fmt.funct3)
                    3'b000:  id_ex_d.alu_op = rv_exec_pkg::op_lb;
                    3'b001:  id_ex_d.alu_op = rv_exec_pkg::op_lh;
                    3'b010:  id_ex_d.alu_op = rv_exec_pkg::op_lw;
                    3'b100:  id_ex_d.alu_op = rv_exec_pkg::op_lbu;
                    3'b101:  id_ex_d.alu_op = rv_exec_pkg::op_lhu;
                    default: id_ex_d.alu_op = rv_exec_pkg::op_none;
                endcase
            end
            rv_exec_pkg::opc_store: begin
                id_ex_d.reg2 = imm_s;
                case (inst_i.s_fmt.funct3)
                    3'b000:  id_ex_d.alu_op = rv_exec_pkg::op_sb;
                    3'b001:  id_ex_d.alu_op = rv_exec_pkg::op_sh;
                    3'b010:  id_ex_d.alu_op = rv_exec_pkg::op_sw;
                    default: id_ex_d.alu_op = rv_exec_pkg::op_none;
                endcase
            end
            rv_exec_pkg::opc_op_imm, rv_exec_pkg::opc_op: begin
                if (inst_i.r_fmt.opcode == rv_exec_pkg::opc_op_imm) begin
                    id_ex_d.reg2 = imm_i;
                end
                case (inst_i.r_fmt.funct3)
                    3'b000: begin
                        // Only the register form has a subtract
                        if (inst_i.r_fmt.opcode == rv_exec_pkg::opc_op
                                && inst_i.r_fmt.funct7[5]) begin
                            id_ex_d.alu_op = rv_exec_pkg::op_sub;
                        end else begin
                            id_ex_d.alu_op = rv_exec_pkg::op_add;
                        end
                    end
                    3'b001: id_ex_d.alu_op = rv_exec_pkg::op_sll;
                    3'b010: id_ex_d.alu_op = rv_exec_pkg::op_slt;
                    3'b011: id_ex_d.alu_op = rv_exec_pkg::op_sltu;
                    3'b100: id_ex_d.alu_op = rv_exec_pkg::op_xor;
                    3'b101: begin
                        if (inst_i.r_fmt.funct7[5]) begin
                            id_ex_d.alu_op = rv_exec_pkg::op_sra;
                        end else begin
                            id_ex_d.alu_op = rv_exec_pkg::op_srl;
                        end
                    end
                    3'b110: id_ex_d.alu_op = rv_exec_pkg::op_or;
                    default: id_ex_d.alu_op = rv_exec_pkg::op_and;
                endcase
            end
            default: id_ex_d.alu_op = rv_exec_pkg::op_none;
        endcase

        // Loads leave their write to the memory stage outside
        id_ex_d.rd_enable = (inst_i.r_fmt.rd != '0)
                            && (id_ex_d.alu_op != rv_exec_pkg::op_none)
                            && (inst_i.r_fmt.opcode != rv_exec_pkg::opc_load)
                            && (inst_i.r_fmt.opcode != rv_exec_pkg::opc_store);

        if (!inst_valid_i) begin
            id_ex_d.alu_op    = rv_exec_pkg::op_none;
            id_ex_d.rd_enable = 1'b0;
        end
    end

    always_ff @(posedge clk_i) begin
        if (reset_i) begin
            id_ex_o <= '0;
        end else begin
            id_ex_o <= id_ex_d;
        end
    end

endmodule

`default_nettype wire

/* design/reg_file.sv */
`timescale 1ns/1ps
`default_nettype none

module reg_file (
    input  logic                               clk_i,
    input  logic                               reset_i,
    input  logic [rv_exec_pkg::reg_addr_w-1:0] rs1_addr_i,
    input  logic [rv_exec_pkg::reg_addr_w-1:0] rs2_addr_i,
    output logic [rv_exec_pkg::xlen-1:0]       rs1_data_o,
    output logic [rv_exec_pkg::xlen-1:0]       rs2_data_o,
    input  rv_exec_pkg::wb_t                   wb_i
);

    logic [rv_exec_pkg::xlen-1:0] regs_q [32];

    always_ff @(posedge clk_i) begin
        if (reset_i) begin
            for (int i = 0; i < 32; i++) begin
                regs_q[i] <= '0;
            end
        end else if (wb_i.enable && wb_i.addr != '0) begin
            regs_q[wb_i.addr] <= wb_i.data;
        end
    end

    // x0 is hard wired to zero
    assign rs1_data_o = (rs1_addr_i == '0) ? '0 : regs_q[rs1_addr_i];
    assign rs2_data_o = (rs2_addr_i == '0) ? '0 : regs_q[rs2_addr_i];

endmodule

`default_nettype wire

/* design/rv_exec_pkg.sv */
`default_nettype none

package rv_exec_pkg;

    localparam int xlen       = 32;
    localparam int reg_addr_w = 5;
    localparam int alu_op_w   = 5;

    // Register and immediate forms share one ALU operation code
    localparam logic [alu_op_w-1:0] op_none   = 5'd0;
    localparam logic [alu_op_w-1:0] op_lui    = 5'd1;
    localparam logic [alu_op_w-1:0] op_auipc  = 5'd2;
    localparam logic [alu_op_w-1:0] op_add    = 5'd3;
    localparam logic [alu_op_w-1:0] op_sub    = 5'd4;
    localparam logic [alu_op_w-1:0] op_sll    = 5'd5;
    localparam logic [alu_op_w-1:0] op_slt    = 5'd6;
    localparam logic [alu_op_w-1:0] op_sltu   = 5'd7;
    localparam logic [alu_op_w-1:0] op_xor    = 5'd8;
    localparam logic [alu_op_w-1:0] op_srl    = 5'd9;
    localparam logic [alu_op_w-1:0] op_sra    = 5'd10;
    localparam logic [alu_op_w-1:0] op_or     = 5'd11;
    localparam logic [alu_op_w-1:0] op_and    = 5'd12;
    localparam logic [alu_op_w-1:0] op_lb     = 5'd13;
    localparam logic [alu_op_w-1:0] op_lh     = 5'd14;
    localparam logic [alu_op_w-1:0] op_lw     = 5'd15;
    localparam logic [alu_op_w-1:0] op_lbu    = 5'd16;
    localparam logic [alu_op_w-1:0] op_lhu    = 5'd17;
    localparam logic [alu_op_w-1:0] op_sb     = 5'd18;
    localparam logic [alu_op_w-1:0] op_sh     = 5'd19;
    localparam logic [alu_op_w-1:0] op_sw     = 5'd20;
    localparam logic [alu_op_w-1:0] op_jump   = 5'd21;
    localparam logic [alu_op_w-1:0] op_branch = 5'd22;

    localparam logic [6:0] opc_lui    = 7'b0110111;
    localparam logic [6:0] opc_auipc  = 7'b0010111;
    localparam logic [6:0] opc_jal    = 7'b1101111;
    localparam logic [6:0] opc_jalr   = 7'b1100111;
    localparam logic [6:0] opc_branch = 7'b1100011;
    localparam logic [6:0] opc_load   = 7'b0000011;
    localparam logic [6:0] opc_store  = 7'b0100011;
    localparam logic [6:0] opc_op_imm = 7'b0010011;
    localparam logic [6:0] opc_op     = 7'b0110011;

    typedef struct packed {
        logic [6:0]            funct7;
        logic [reg_addr_w-1:0] rs2;
        logic [reg_addr_w-1:0] rs1;
        logic [2:0]            funct3;
        logic [reg_addr_w-1:0] rd;
        logic [6:0]            opcode;
    } r_fmt_t;

    typedef struct packed {
        logic [11:0]           imm;
        logic [reg_addr_w-1:0] rs1;
        logic [2:0]            funct3;
        logic [reg_addr_w-1:0] rd;
        logic [6:0]            opcode;
    } i_fmt_t;

    typedef struct packed {
        logic [6:0]            imm_hi;
        logic [reg_addr_w-1:0] rs2;
        logic [reg_addr_w-1:0] rs1;
        logic [2:0]            funct3;
        logic [4:0]            imm_lo;
        logic [6:0]            opcode;
    } s_fmt_t;

    typedef struct packed {
        logic [19:0]           imm;
        logic [reg_addr_w-1:0] rd;
        logic [6:0]            opcode;
    } u_fmt_t;

    // One instruction word seen through the base formats
    typedef union packed {
        r_fmt_t r_fmt;
        i_fmt_t i_fmt;
        s_fmt_t s_fmt;
        u_fmt_t u_fmt;
    } rv_inst_u;

    typedef struct packed {
        logic [xlen-1:0]       reg1;
        logic [xlen-1:0]       reg2;
        logic [xlen-1:0]       store_data;
        logic [reg_addr_w-1:0] rd;
        logic                  rd_enable;
        logic [alu_op_w-1:0]   alu_op;
        logic [xlen-1:0]       addr_for_rd;
    } id_ex_t;

    typedef struct packed {
        logic [xlen-1:0]       rd_data;
        logic [reg_addr_w-1:0] rd_addr;
        logic                  rd_enable;
        logic [xlen-1:0]       mem_addr;
        logic [xlen-1:0]       mem_wdata;
        logic [alu_op_w-1:0]   alu_op;
    } ex_res_t;

    typedef struct packed {
        logic                  enable;
        logic [reg_addr_w-1:0] addr;
        logic [xlen-1:0]       data;
    } wb_t;

    typedef struct packed {
        logic                valid;
        logic [alu_op_w-1:0] op;
        logic [xlen-1:0]     addr;
        logic [xlen-1:0]     wdata;
    } mem_req_t;

endpackage

`default_nettype wire

/* filelist.f */
design/rv_exec_pkg.sv
design/reg_file.sv
design/inst_decode.sv
design/alu_exec.sv
design/ex_mem_reg.sv
design/exec_core_top.sv
verification/exec_core_tb.sv

/* verification/exec_core_tb.sv */
`timescale 1ns/1ps
`default_nettype none

module exec_core_tb;

    // The tests run for about 150 cycles and this leaves a wide margin
    localparam int max_cycles = 2000;

    logic                  clk;
    logic                  reset;
    logic                  inst_valid;
    logic [31:0]           inst_word;
    logic [31:0]           pc;
    rv_exec_pkg::wb_t      wb;
    rv_exec_pkg::mem_req_t mem_req;

    logic [31:0]           model_regs [32];
    rv_exec_pkg::wb_t      exp_wb     [3];
    rv_exec_pkg::mem_req_t exp_mem    [3];
    logic                  exp_store  [3];
    logic [31:0]           lcg_state;
    logic [31:0]           pc_next;
    int                    cycle_count;

    exec_core_top dut_i (
        .clk_i        (clk),
        .reset_i      (reset),
        .inst_valid_i (inst_valid),
        .inst_i       (inst_word),
        .pc_i         (pc),
        .wb_o         (wb),
        .mem_req_o    (mem_req)
    );

    always #50 clk = ~clk;

    always @(posedge clk) begin
        cycle_count <= cycle_count + 1;
        if (cycle_count >= max_cycles) begin
            $display("Timeout: the run did not finish within %0d cycles", max_cycles);
            $display("test failed");
            $fatal(1, "Timeout");
        end
    end

    function automatic logic [31:0] lcg_next();
        lcg_state = lcg_state * 32'd1664525 + 32'd1013904223;
        return lcg_state;
    endfunction

    // RV32I integer semantics where alt selects SUB and SRA
    function automatic logic [31:0] alu_ref(input logic [2:0] f3, input logic alt,
                                            input logic [31:0] a, input logic [31:0] b);
        logic [31:0] r;
        case (f3)
            3'b000:  r = alt ? a - b : a + b;
            3'b001:  r = a << b[4:0];
            3'b010:  r = ($signed(a) < $signed(b)) ? 32'd1 : 32'd0;
            3'b011:  r = (a < b) ? 32'd1 : 32'd0;
            3'b100:  r = a ^ b;
            3'b101:  r = alt ? $unsigned($signed(a) >>> b[4:0]) : a >> b[4:0];
            3'b110:  r = a | b;
            default: r = a & b;
        endcase
        return r;
    endfunction

    function automatic rv_exec_pkg::wb_t write_expect(input logic [4:0] rd,
                                                      input logic [31:0] data);
        rv_exec_pkg::wb_t w;
        w.enable = (rd != 5'd0);
        w.addr   = rd;
        w.data   = data;
        return w;
    endfunction

    task automatic check_equal(input string name, input logic [31:0] got,
                               input logic [31:0] exp);
        if (got !== exp) begin
            $display("FAIL %s: got 0x%08h, expected 0x%08h", name, got, exp);
            $display("test failed");
            $fatal(1, "Value mismatch");
        end
    endtask

    task automatic check_outputs();
        check_equal("wb_o.enable", 32'(wb.enable), 32'(exp_wb[2].enable));
        if (exp_wb[2].enable) begin
            check_equal("wb_o.addr", 32'(wb.addr), 32'(exp_wb[2].addr));
            check_equal("wb_o.data", wb.data, exp_wb[2].data);
        end
        check_equal("mem_req_o.valid", 32'(mem_req.valid), 32'(exp_mem[2].valid));
        if (exp_mem[2].valid) begin
            check_equal("mem_req_o.op", 32'(mem_req.op), 32'(exp_mem[2].op));
            check_equal("mem_req_o.addr", mem_req.addr, exp_mem[2].addr);
            if (exp_store[2]) begin
                check_equal("mem_req_o.wdata", mem_req.wdata, exp_mem[2].wdata);
            end
        end
    endtask

    // Drive one slot and check the slot issued two cycles earlier
    task automatic step(input logic valid, input logic [31:0] word,
                        input rv_exec_pkg::wb_t wb_exp, input rv_exec_pkg::mem_req_t mem_exp,
                        input logic store);
        @(posedge clk);
        inst_valid <= valid;
        inst_word  <= word;
        pc         <= pc_next;
        exp_wb[2]    = exp_wb[1];
        exp_wb[1]    = exp_wb[0];
        exp_wb[0]    = wb_exp;
        exp_mem[2]   = exp_mem[1];
        exp_mem[1]   = exp_mem[0];
        exp_mem[0]   = mem_exp;
        exp_store[2] = exp_store[1];
        exp_store[1] = exp_store[0];
        exp_store[0] = store;
        if (valid) begin
            pc_next = pc_next + 32'd4;
        end
        if (wb_exp.enable) begin
            model_regs[wb_exp.addr] = wb_exp.data;
        end
        @(negedge clk);
        check_outputs();
    endtask

    // The word is an ADDI to x31 that must not write without the strobe
    task automatic idle();
        step(1'b0, {12'h7ff, 5'd0, 3'b000, 5'd31, rv_exec_pkg::opc_op_imm}, '0, '0, 1'b0);
    endtask

    task automatic issue_alu(input logic is_imm, input logic [2:0] f3, input logic alt,
                             input logic [4:0] rd, input logic [4:0] rs1, input logic [4:0] rs2,
                             input logic [11:0] imm);
        logic [11:0] imm_l;
        logic [31:0] b;
        logic [31:0] word;
        logic        alt_l;
        imm_l = imm;
        if (f3 == 3'b001) begin
            imm_l = {7'b0, imm[4:0]};
        end else if (f3 == 3'b101) begin
            imm_l = {1'b0, imm[10], 5'b0, imm[4:0]};
        end
        if (is_imm) begin
            b     = {{20{imm_l[11]}}, imm_l};
            alt_l = (f3 == 3'b101) && imm_l[10];
            word  = {imm_l, rs1, f3, rd, rv_exec_pkg::opc_op_imm};
        end else begin
            b     = model_regs[rs2];
            alt_l = alt;
            word  = {1'b0, alt, 5'b0, rs2, rs1, f3, rd, rv_exec_pkg::opc_op};
        end
        step(1'b1, word, write_expect(rd, alu_ref(f3, alt_l, model_regs[rs1], b)), '0, 1'b0);
    endtask

    task automatic load_reg(input logic [4:0] rd, input logic [31:0] value);
        logic [31:0] low;
        logic [31:0] upper;
        low   = {{20{value[11]}}, value[11:0]};
        upper = value - low;
        issue_upper(1'b0, rd, upper[31:12]);
        issue_alu(1'b1, 3'b000, 1'b0, rd, rd, 5'd0, value[11:0]);
    endtask

    task automatic issue_upper(input logic is_auipc, input logic [4:0] rd,
                               input logic [19:0] imm);
        logic [31:0] value;
        logic [6:0]  opc;
        value = {imm, 12'b0};
        opc   = rv_exec_pkg::opc_lui;
        if (is_auipc) begin
            value = value + pc_next;
            opc   = rv_exec_pkg::opc_auipc;
        end
        step(1'b1, {imm, rd, opc}, write_expect(rd, value), '0, 1'b0);
    endtask

    task automatic issue_jump(input logic is_jalr, input logic [4:0] rd, input logic [4:0] rs1,
                              input logic [20:0] imm);
        logic [31:0] word;
        if (is_jalr) begin
            word = {imm[11:0], rs1, 3'b000, rd, rv_exec_pkg::opc_jalr};
        end else begin
            word = {imm[20], imm[10:1], imm[11], imm[19:12], rd, rv_exec_pkg::opc_jal};
        end
        step(1'b1, word, write_expect(rd, pc_next + 32'd4), '0, 1'b0);
    endtask

    task automatic issue_branch(input logic [2:0] f3, input logic [4:0] rs1,
                                input logic [4:0] rs2, input logic [12:0] imm);
        logic [31:0] word;
        word = {imm[12], imm[10:5], rs2, rs1, f3, imm[4:1], imm[11], rv_exec_pkg::opc_branch};
        step(1'b1, word, '0, '0, 1'b0);
    endtask

    // rs2_rd is the destination of a load and the data source of a store
    task automatic issue_mem(input logic is_store, input logic [2:0] f3, input logic [4:0] rs1,
                             input logic [4:0] rs2_rd, input logic [11:0] imm);
        rv_exec_pkg::mem_req_t m;
        logic [31:0]           word;
        m.valid = 1'b1;
        m.addr  = model_regs[rs1] + {{20{imm[11]}}, imm};
        m.wdata = model_regs[rs2_rd];
        if (is_store) begin
            word = {imm[11:5], rs2_rd, rs1, f3, imm[4:0], rv_exec_pkg::opc_store};
            case (f3)
                3'b000:  m.op = rv_exec_pkg::op_sb;
                3'b001:  m.op = rv_exec_pkg::op_sh;
                default: m.op = rv_exec_pkg::op_sw;
            endcase
        end else begin
            word = {imm, rs1, f3, rs2_rd, rv_exec_pkg::opc_load};
            case (f3)
                3'b000:  m.op = rv_exec_pkg::op_lb;
                3'b001:  m.op = rv_exec_pkg::op_lh;
                3'b010:  m.op = rv_exec_pkg::op_lw;
                3'b100:  m.op = rv_exec_pkg::op_lbu;
                default: m.op = rv_exec_pkg::op_lhu;
            endcase
        end
        step(1'b1, word, '0, m, is_store);
    endtask

    task automatic test_reset();
        logic [31:0] word;
        // An ADDI strobed during reset must never reach the outputs
        word = {12'h001, 5'd0, 3'b000, 5'd1, rv_exec_pkg::opc_op_imm};
        for (int i = 0; i < 4; i++) begin
            @(posedge clk);
            if (i == 3) begin
                reset      <= 1'b0;
                inst_valid <= 1'b0;
            end else begin
                inst_valid <= 1'b1;
                inst_word  <= word;
            end
            @(negedge clk);
            check_equal("wb_o.enable", 32'(wb.enable), 32'd0);
            check_equal("mem_req_o.valid", 32'(mem_req.valid), 32'd0);
        end
        repeat (3) idle();
    endtask

    task automatic test_alu();
        logic [31:0] r;
        logic [2:0]  f3;
        for (int i = 0; i < 8; i++) begin
            f3 = 3'(i);
            load_reg(5'd1, lcg_next());
            load_reg(5'd2, lcg_next());
            r = lcg_next();
            issue_alu(1'b0, f3, 1'b0, 5'd3, 5'd1, 5'd2, 12'd0);
            if (f3 == 3'b000 || f3 == 3'b101) begin
                issue_alu(1'b0, f3, 1'b1, 5'd4, 5'd1, 5'd2, 12'd0);
            end
            issue_alu(1'b1, f3, 1'b0, 5'd5, 5'd1, 5'd0, r[31:20] & 12'hbff);
            if (f3 == 3'b101) begin
                issue_alu(1'b1, f3, 1'b0, 5'd6, 5'd2, 5'd0, r[31:20] | 12'h400);
            end
        end
        // Results aimed at x0 are dropped
        issue_alu(1'b0, 3'b000, 1'b0, 5'd0, 5'd1, 5'd2, 12'd0);
        issue_alu(1'b1, 3'b110, 1'b0, 5'd0, 5'd1, 5'd0, 12'h7ff);
    endtask

    task automatic test_forwarding();
        load_reg(5'd5, lcg_next());
        issue_alu(1'b1, 3'b000, 1'b0, 5'd6, 5'd5, 5'd0, 12'h123);
        // x6 is one slot old here and x5 two
        issue_alu(1'b0, 3'b000, 1'b1, 5'd7, 5'd5, 5'd6, 12'd0);
        issue_alu(1'b1, 3'b100, 1'b0, 5'd8, 5'd0, 5'd0, 12'h055);
        issue_alu(1'b0, 3'b100, 1'b0, 5'd9, 5'd7, 5'd6, 12'd0);
        // After two writes in a row the younger one must win
        issue_alu(1'b1, 3'b000, 1'b0, 5'd10, 5'd0, 5'd0, 12'h005);
        issue_alu(1'b1, 3'b000, 1'b0, 5'd10, 5'd0, 5'd0, 12'h009);
        issue_alu(1'b0, 3'b000, 1'b0, 5'd11, 5'd10, 5'd10, 12'd0);
        issue_alu(1'b1, 3'b000, 1'b0, 5'd10, 5'd0, 5'd0, 12'h0aa);
        idle();
        issue_alu(1'b0, 3'b110, 1'b0, 5'd12, 5'd11, 5'd10, 12'd0);
        issue_alu(1'b1, 3'b000, 1'b0, 5'd10, 5'd10, 5'd0, 12'h001);
        idle();
        idle();
        issue_alu(1'b0, 3'b000, 1'b0, 5'd13, 5'd10, 5'd12, 12'd0);
    endtask

    task automatic test_upper_jump();
        logic [31:0] r;
        r = lcg_next();
        issue_upper(1'b0, 5'd13, r[31:12]);
        issue_upper(1'b1, 5'd14, r[19:0]);
        issue_jump(1'b0, 5'd15, 5'd0, 21'h000804);
        issue_jump(1'b1, 5'd16, 5'd13, 21'h1ffff8);
        issue_jump(1'b0, 5'd0, 5'd0, 21'h000010);
        issue_branch(3'b001, 5'd13, 5'd14, 13'h0ff0);
        issue_alu(1'b0, 3'b000, 1'b0, 5'd17, 5'd15, 5'd16, 12'd0);
    endtask

    task automatic test_mem();
        logic [31:0] r;
        load_reg(5'd20, lcg_next());
        for (int i = 0; i < 6; i++) begin
            r = lcg_next();
            if (i != 3) begin
                issue_mem(1'b0, 3'(i), 5'd20, 5'd22, r[31:20]);
            end
        end
        // x22 still holds its old value because the loads never wrote it
        issue_alu(1'b0, 3'b000, 1'b0, 5'd23, 5'd22, 5'd0, 12'd0);
        for (int i = 0; i < 3; i++) begin
            load_reg(5'd21, lcg_next());
            r = lcg_next();
            issue_mem(1'b1, 3'(i), 5'd20, 5'd21, r[31:20]);
        end
    endtask

    task automatic test_stream();
        logic [31:0] r;
        logic [31:0] v;
        logic [4:0]  rd;
        logic [4:0]  rs1;
        logic [4:0]  rs2;
        logic [2:0]  f3;
        logic        alt;
        for (int i = 0; i < 50; i++) begin
            r   = lcg_next();
            v   = lcg_next();
            rd  = {2'b0, r[31:29]};
            rs1 = {2'b0, r[28:26]};
            rs2 = {2'b0, r[25:23]};
            f3  = r[19:17];
            alt = r[16] && (f3 == 3'b000 || f3 == 3'b101);
            case (r[22:20])
                3'd0: issue_alu(1'b0, f3, alt, rd, rs1, rs2, 12'd0);
                3'd1: issue_alu(1'b1, f3, 1'b0, rd, rs1, 5'd0, v[31:20]);
                3'd2: issue_upper(1'b0, rd, v[31:12]);
                3'd3: issue_upper(1'b1, rd, v[31:12]);
                3'd4: issue_jump(1'b0, rd, 5'd0, {v[31:12], 1'b0});
                3'd5: issue_jump(1'b1, rd, rs1, {9'd0, v[31:20]});
                3'd6: begin
                    if (r[16]) begin
                        f3 = (f3[1:0] == 2'b11) ? 3'b010 : {1'b0, f3[1:0]};
                    end else if (f3 == 3'b011 || f3[2:1] == 2'b11) begin
                        f3 = 3'b010;
                    end
                    issue_mem(r[16], f3, rs1, rs2, v[31:20]);
                end
                default: issue_branch(f3, rs1, rs2, {v[31:20], 1'b0});
            endcase
        end
    endtask

    initial begin
        clk         = 1'b0;
        reset       <= 1'b1;
        inst_valid  <= 1'b0;
        inst_word   <= 32'd0;
        pc          <= 32'd0;
        cycle_count <= 0;
        lcg_state   = 32'd66;
        pc_next     = 32'h0000_1000;
        for (int i = 0; i < 32; i++) begin
            model_regs[i] = 32'd0;
        end
        for (int i = 0; i < 3; i++) begin
            exp_wb[i]    = '0;
            exp_mem[i]   = '0;
            exp_store[i] = 1'b0;
        end

        test_reset();
        test_alu();
        test_forwarding();
        test_upper_jump();
        test_mem();
        test_stream();
        // Let the last two slots reach the outputs
        idle();
        idle();

        $display("test passed");
        $finish;
    end

endmodule

`default_nettype wire
